//--- dcache_hit.f
logic/dcache_pkg.sv
logic/dcache_req_decode.sv
logic/dcache_write_buffer.sv
logic/dcache_miss_fsm.sv
logic/dcache_read_path.sv
logic/dcache_hit.sv
dv/dcache_hit_tb.sv

//--- dv/dcache_hit_tb.sv
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the data cache hit stage. Reads vectors
// from dv/dcache_hit_tests.txt, plays cache memory and bus interface,
// and checks load data, the write buffer and the miss sequence.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dcache_hit_tb import dcache_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned     WAYS     = 2;
  localparam int unsigned     MAX_VEC  = 64;
  localparam logic [WAYS-1:0] FILL_WAY = 2'b10;

  logic            clk_i, rst_ni;
  logic            req_i, wreq_i, cacheable_i, pma_exception_i, pmp_exception_i;
  adr_t            adr_i, biu_adro_i;
  word_be_t        be_i;
  word_t           d_i, biu_q_i, q_o;
  logic            cache_hit_i, way_dirty_i;
  logic [WAYS-1:0] ways_hit_i, fill_way_i, fill_way_o, writebuffer_ways_hit_o;
  line_t           cache_line_i;
  logic            writebuffer_ack_i, biucmd_ack_i, biucmd_busy_i, biu_ack_i, biu_err_i;
  logic            stall_o, ack_o, err_o, armed_o, filling_o, writebuffer_we_o;
  idx_t            idx_o, writebuffer_idx_o;
  tag_t            core_tag_o;
  dat_offs_t       writebuffer_offs_o;
  word_t           writebuffer_data_o;
  line_be_t        writebuffer_be_o;
  biucmd_e         biucmd_o;

  // test vectors
  logic [8*16-1:0] vec_name  [MAX_VEC];
  logic [8*8-1:0]  vec_kind  [MAX_VEC];
  adr_t            vec_adr   [MAX_VEC];
  word_t           vec_d     [MAX_VEC];
  word_be_t        vec_be    [MAX_VEC];
  logic            vec_hit   [MAX_VEC];
  logic            vec_dirty [MAX_VEC];
  line_t           vec_line  [MAX_VEC];
  word_t           vec_exp   [MAX_VEC];

  int              n_vec       = 0;
  int              errors      = 0;
  int              cycles      = 0;
  int              cycle_limit = 0;
  logic [8*16-1:0] cur_name;

  dcache_hit #(.WAYS(WAYS)) dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // run limit scales with the number of vectors
  always @(posedge clk_i) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("TEST FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////
  task automatic check(input string what, input logic [127:0] exp_val,
                       input logic [127:0] act_val);
    if (act_val !== exp_val) begin
      errors++;
      $display("[ERROR] %0s %0s: expected %0h, actual %0h", cur_name, what, exp_val, act_val);
    end
  endtask

  task automatic read_vectors();
    int              fd;
    int              r;
    logic [8*16-1:0] tok;
    logic [8*200-1:0] rest;
    fd = $fopen("dv/dcache_hit_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open the test vector file dv/dcache_hit_tests.txt");
      errors++;
    end else begin
      while (!$feof(fd) && n_vec < MAX_VEC) begin
        r = $fscanf(fd, "%s", tok);
        if (r == 1 && tok == "#") begin
          r = $fgets(rest, fd);
        end else if (r == 1) begin
          vec_name[n_vec] = tok;
          r = $fscanf(fd, "%s %h %h %h %h %h %h %h", vec_kind[n_vec], vec_adr[n_vec],
                      vec_d[n_vec], vec_be[n_vec], vec_hit[n_vec], vec_dirty[n_vec],
                      vec_line[n_vec], vec_exp[n_vec]);
          if (r == 8) begin
            n_vec++;
          end else begin
            $display("test vector %0s is incomplete", tok);
            errors++;
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #2;
  endtask

  task automatic drive_idle();
    req_i             = 1'b0;
    wreq_i            = 1'b0;
    pma_exception_i   = 1'b0;
    pmp_exception_i   = 1'b0;
    writebuffer_ack_i = 1'b0;
    biucmd_ack_i      = 1'b0;
    biu_ack_i         = 1'b0;
    biu_err_i         = 1'b0;
  endtask

  task automatic init_inputs();
    drive_idle();
    cacheable_i   = 1'b0;
    adr_i         = '0;
    be_i          = '0;
    d_i           = '0;
    cache_hit_i   = 1'b0;
    ways_hit_i    = '0;
    cache_line_i  = '0;
    way_dirty_i   = 1'b0;
    fill_way_i    = '0;
    biucmd_busy_i = 1'b0;
    biu_q_i       = '0;
    biu_adro_i    = '0;
  endtask

  task automatic drive_request(input int k, input logic write);
    req_i        = 1'b1;
    wreq_i       = write;
    cacheable_i  = 1'b1;
    adr_i        = vec_adr[k];
    d_i          = vec_d[k];
    be_i         = vec_be[k];
    cache_hit_i  = vec_hit[k];
    ways_hit_i   = vec_hit[k] ? 2'b01 : 2'b00;
    cache_line_i = vec_line[k];
    way_dirty_i  = vec_dirty[k];
    fill_way_i   = FILL_WAY;
  endtask

  //////////////////////////////////////////////////////////////////////
  // one task per kind of vector
  //////////////////////////////////////////////////////////////////////
  task automatic run_load(input int k);
    drive_request(k, 1'b0);
    #1;
    check("stall_o", 0, stall_o);
    // tag is bits 31:9 and index bits 8:4
    check("idx_o", vec_adr[k][8:4], idx_o);
    check("core_tag_o", vec_adr[k][31:9], core_tag_o);
    next_cycle();
    drive_idle();
    check("ack_o", 1, ack_o);
    check("q_o", vec_exp[k], q_o);
  endtask

  task automatic run_store(input int k);
    line_be_t exp_be;
    exp_be = '0;
    // word enables land at byte lane 4 * word offset
    for (int j = 0; j < 4; j++) begin
      exp_be[4 * vec_adr[k][3:2] + j] = vec_be[k][j];
    end
    drive_request(k, 1'b1);
    next_cycle();
    drive_idle();
    check("writebuffer_we_o", 1, writebuffer_we_o);
    check("writebuffer_idx_o", vec_adr[k][8:4], writebuffer_idx_o);
    check("writebuffer_offs_o", vec_adr[k][3:2], writebuffer_offs_o);
    check("writebuffer_data_o", vec_d[k], writebuffer_data_o);
    check("writebuffer_be_o", exp_be, writebuffer_be_o);
    check("writebuffer_ways_hit_o", 2'b01, writebuffer_ways_hit_o);
    next_cycle();
    check("writebuffer_we_o held", 1, writebuffer_we_o);
    check("writebuffer_data_o held", vec_d[k], writebuffer_data_o);
    check("writebuffer_be_o held", exp_be, writebuffer_be_o);
  endtask

  task automatic run_wback();
    check("writebuffer_we_o before ack", 1, writebuffer_we_o);
    writebuffer_ack_i = 1'b1;
    next_cycle();
    writebuffer_ack_i = 1'b0;
    check("writebuffer_we_o after ack", 0, writebuffer_we_o);
  endtask

  task automatic run_miss(input int k);
    drive_request(k, 1'b0);
    #1;
    check("stall_o on miss", 1, stall_o);
    next_cycle();
    while (biucmd_o !== BIUCMD_READWAY) begin
      next_cycle();
    end
    check("filling_o", 1, filling_o);
    check("fill_way_o", FILL_WAY, fill_way_o);
    check("stall_o while filling", 1, stall_o);
    next_cycle();
    check("biucmd_o after read", BIUCMD_NOP, biucmd_o);
    next_cycle();
    next_cycle();
    // bus answers three cycles after the command
    biucmd_ack_i = 1'b1;
    biu_ack_i    = 1'b1;
    biu_adro_i   = vec_adr[k];
    biu_q_i      = vec_exp[k];
    next_cycle();
    drive_idle();
    check("ack_o", 1, ack_o);
    check("q_o", vec_exp[k], q_o);
    check("biucmd_o", vec_dirty[k] ? BIUCMD_WRITEWAY : BIUCMD_NOP, biucmd_o);
    check("fill_way_o", FILL_WAY, fill_way_o);
    check("filling_o done", 0, filling_o);
    #1;
    check("stall_o recover0", 1, stall_o);
    next_cycle();
    check("biucmd_o recover1", BIUCMD_NOP, biucmd_o);
    check("armed_o recover1", 0, armed_o);
    check("stall_o recover1", 1, stall_o);
    next_cycle();
    check("armed_o", 1, armed_o);
    check("stall_o armed", 0, stall_o);
  endtask

  task automatic run_error(input int k, input logic pmp);
    // once with the vector's hit flag and once with it flipped
    for (int attempt = 0; attempt < 2; attempt++) begin
      drive_request(k, 1'b0);
      cache_hit_i     = vec_hit[k] ^ (attempt == 1);
      pma_exception_i = ~pmp;
      pmp_exception_i = pmp;
      #1;
      check("stall_o", 0, stall_o);
      next_cycle();
      drive_idle();
      check("err_o", 1, err_o);
      check("ack_o", 0, ack_o);
      check("biucmd_o", BIUCMD_NOP, biucmd_o);
      check("armed_o", 1, armed_o);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////
  initial begin
    cur_name = "reset";
    rst_ni   = 1'b0;
    init_inputs();
    read_vectors();
    cycle_limit = 30 * n_vec + 20;
    repeat (8) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    check("ack_o", 0, ack_o);
    check("writebuffer_we_o", 0, writebuffer_we_o);
    check("filling_o", 0, filling_o);
    check("biucmd_o", BIUCMD_NOP, biucmd_o);
    check("armed_o", 1, armed_o);

    for (int k = 0; k < n_vec; k++) begin
      cur_name = vec_name[k];
      case (vec_kind[k])
        "load":   run_load(k);
        "store":  run_store(k);
        "wback":  run_wback();
        "miss":   run_miss(k);
        "pmaerr": run_error(k, 1'b0);
        "pmperr": run_error(k, 1'b1);
        default: begin
          $display("vector %0s has an unknown kind", vec_name[k]);
          errors++;
        end
      endcase
    end
    next_cycle();

    $display("%0d errors in %0d test vectors", errors, n_vec);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/dcache_hit_tests.txt
# columns: name kind address store_data byte_en hit dirty line(128b hex) expected_word
# kinds: load, store, wback (write buffer ack), miss, pmaerr, pmperr
ld_w0 load 00001040 00000000 0 1 0 44444444333333332222222211111111 11111111
ld_w1 load 00001044 00000000 0 1 0 44444444333333332222222211111111 22222222
ld_w2 load 00001048 00000000 0 1 0 44444444333333332222222211111111 33333333
ld_w3 load 0000104c 00000000 0 1 0 44444444333333332222222211111111 44444444
ld_hi_tag load 20000a58 00000000 0 1 0 deadbeefcafef00d0123456789abcdef cafef00d
st_lo_half store 00001044 a5a5a5a5 3 1 0 0 0
byp_same load 00001044 00000000 0 1 0 44444444333333332222222211111111 2222a5a5
byp_other load 0000104c 00000000 0 1 0 44444444333333332222222211111111 44444444
byp_tag load 00003044 00000000 0 1 0 44444444333333332222222211111111 2222a5a5
nobyp_idx load 00001054 00000000 0 1 0 44444444333333332222222211111111 22222222
wb_ack_1 wback 00000000 00000000 0 0 0 0 0
ld_after_ack load 00001044 00000000 0 1 0 44444444333333332222222211111111 22222222
st_hi_half store 20000a5c 12345678 c 1 0 0 0
byp_hi load 20000a5c 00000000 0 1 0 deadbeefcafef00d0123456789abcdef 1234beef
st_reload store 00001048 0badf00d f 1 0 0 0
byp_reload load 00001048 00000000 0 1 0 44444444333333332222222211111111 0badf00d
old_gone load 20000a5c 00000000 0 1 0 deadbeefcafef00d0123456789abcdef deadbeef
wb_ack_2 wback 00000000 00000000 0 0 0 0 0
miss_clean miss 00002040 00000000 0 0 0 0 600dcafe
ld_post_miss load 00002044 00000000 0 1 0 44444444333333332222222211111111 22222222
miss_dirty miss 00004a58 00000000 0 0 1 0 d1a7b00c
err_pma pmaerr 00001040 00000000 0 1 0 0 0
err_pmp pmperr 00001040 00000000 0 1 0 0 0
ld_final load 00001040 00000000 0 1 0 44444444333333332222222211111111 11111111

//--- logic/dcache_hit.sv
//////////////////////////////////////////////////////////////////////
// Hit stage of a set-associative data cache. Decodes the request,
// buffers store hits, runs the miss FSM towards the bus interface and
// returns load data. WAYS is set here and passed down.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dcache_hit import dcache_pkg::*; #(
  parameter int unsigned WAYS = 2
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,

  // core side
  input  wire logic            req_i,
  input  wire logic            wreq_i,
  input  wire logic            cacheable_i,
  input  wire logic            pma_exception_i,
  input  wire logic            pmp_exception_i,
  input  wire adr_t            adr_i,
  input  wire word_be_t        be_i,
  input  wire word_t           d_i,
  output      logic            stall_o,
  output      word_t           q_o,
  output      logic            ack_o,
  output      logic            err_o,

  // cache memories
  input  wire logic            cache_hit_i,
  input  wire logic [WAYS-1:0] ways_hit_i,
  input  wire line_t           cache_line_i,
  input  wire logic            way_dirty_i,
  input  wire logic [WAYS-1:0] fill_way_i,
  output      logic            armed_o,
  output      logic            filling_o,
  output      logic [WAYS-1:0] fill_way_o,
  output      idx_t            idx_o,
  output      tag_t            core_tag_o,

  // write buffer
  input  wire logic            writebuffer_ack_i,
  output      logic            writebuffer_we_o,
  output      idx_t            writebuffer_idx_o,
  output      dat_offs_t       writebuffer_offs_o,
  output      word_t           writebuffer_data_o,
  output      line_be_t        writebuffer_be_o,
  output      logic [WAYS-1:0] writebuffer_ways_hit_o,

  // bus interface
  output      biucmd_e         biucmd_o,
  input  wire logic            biucmd_ack_i,
  input  wire logic            biucmd_busy_i,
  input  wire word_t           biu_q_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_err_i,
  input  wire adr_t            biu_adro_i
);

  logic          valid_req;
  logic          access_err;
  logic          load_hit;
  logic          store_hit;
  logic          miss_req;
  dat_offs_t     dat_offs;
  logic          biu_match;
  memfsm_state_e memfsm_state;

  dcache_req_decode u_req_decode (
    .req_i           (req_i),
    .wreq_i          (wreq_i),
    .cacheable_i     (cacheable_i),
    .cache_hit_i     (cache_hit_i),
    .pma_exception_i (pma_exception_i),
    .pmp_exception_i (pmp_exception_i),
    .adr_i           (adr_i),
    .valid_req_o     (valid_req),
    .access_err_o    (access_err),
    .load_hit_o      (load_hit),
    .store_hit_o     (store_hit),
    .miss_req_o      (miss_req),
    .idx_o           (idx_o),
    .tag_o           (core_tag_o),
    .dat_offs_o      (dat_offs)
  );

  dcache_write_buffer #(.WAYS(WAYS)) u_write_buffer (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .store_hit_i       (store_hit),
    .idx_i             (idx_o),
    .dat_offs_i        (dat_offs),
    .d_i               (d_i),
    .be_i              (be_i),
    .ways_hit_i        (ways_hit_i),
    .writebuffer_ack_i (writebuffer_ack_i),
    .we_o              (writebuffer_we_o),
    .idx_o             (writebuffer_idx_o),
    .offs_o            (writebuffer_offs_o),
    .data_o            (writebuffer_data_o),
    .be_o              (writebuffer_be_o),
    .ways_hit_o        (writebuffer_ways_hit_o)
  );

  dcache_miss_fsm #(.WAYS(WAYS)) u_miss_fsm (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .miss_req_i    (miss_req),
    .valid_req_i   (valid_req),
    .cache_hit_i   (cache_hit_i),
    .way_dirty_i   (way_dirty_i),
    .fill_way_i    (fill_way_i),
    .biucmd_ack_i  (biucmd_ack_i),
    .biucmd_busy_i (biucmd_busy_i),
    .biu_err_i     (biu_err_i),
    .biu_ack_i     (biu_ack_i),
    .biu_match_i   (biu_match),
    .state_o       (memfsm_state),
    .biucmd_o      (biucmd_o),
    .fill_way_o    (fill_way_o),
    .armed_o       (armed_o),
    .filling_o     (filling_o),
    .stall_o       (stall_o)
  );

  dcache_read_path u_read_path (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .state_i      (memfsm_state),
    .load_hit_i   (load_hit),
    .idx_i        (idx_o),
    .dat_offs_i   (dat_offs),
    .adr_i        (adr_i),
    .cache_line_i (cache_line_i),
    .wb_we_i      (writebuffer_we_o),
    .wb_idx_i     (writebuffer_idx_o),
    .wb_be_i      (writebuffer_be_o),
    .wb_data_i    (writebuffer_data_o),
    .biu_q_i      (biu_q_i),
    .biu_ack_i    (biu_ack_i),
    .biu_adro_i   (biu_adro_i),
    .biu_err_i    (biu_err_i),
    .access_err_i (access_err),
    .biu_match_o  (biu_match),
    .q_o          (q_o),
    .ack_o        (ack_o),
    .err_o        (err_o)
  );

endmodule

`default_nettype wire

//--- logic/dcache_miss_fsm.sv
//////////////////////////////////////////////////////////////////////
// Miss FSM. Issues read-way and write-way commands to the bus
// interface, stalls the core while a line is fetched and adds two
// recovery cycles before the stage is armed again.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dcache_miss_fsm import dcache_pkg::*; #(
  parameter int unsigned WAYS = 2
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            miss_req_i,
  input  wire logic            valid_req_i,
  input  wire logic            cache_hit_i,
  input  wire logic            way_dirty_i,
  input  wire logic [WAYS-1:0] fill_way_i,
  input  wire logic            biucmd_ack_i,
  input  wire logic            biucmd_busy_i,
  input  wire logic            biu_err_i,
  input  wire logic            biu_ack_i,
  input  wire logic            biu_match_i,
  output memfsm_state_e        state_o,
  output biucmd_e              biucmd_o,
  output logic [WAYS-1:0]      fill_way_o,
  output logic                 armed_o,
  output logic                 filling_o,
  output logic                 stall_o
);

  memfsm_state_e   nxt_state;
  biucmd_e         nxt_biucmd;
  logic [WAYS-1:0] nxt_fill_way;

  //////////////////////////////////////////////////////////////////////
  // next state and command
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    nxt_state    = state_o;
    nxt_biucmd   = BIUCMD_NOP;
    nxt_fill_way = fill_way_o;

    case (state_o)
      ARMED: begin
        // wait here while the bus interface is busy
        if (miss_req_i && !biucmd_busy_i) begin
          nxt_fill_way = fill_way_i;
          nxt_biucmd   = BIUCMD_READWAY;
          nxt_state    = way_dirty_i ? EVICT : READ;
        end
      end
      READ: begin
        if (biucmd_ack_i || biu_err_i) begin
          nxt_state = RECOVER0;
        end
      end
      EVICT: begin
        // new line is in, now write back the old one
        if (biucmd_ack_i || biu_err_i) begin
          nxt_state  = RECOVER0;
          nxt_biucmd = BIUCMD_WRITEWAY;
        end
      end
      RECOVER0: nxt_state = RECOVER1;
      RECOVER1: nxt_state = ARMED;
      default:  nxt_state = ARMED;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_o    <= ARMED;
      biucmd_o   <= BIUCMD_NOP;
      fill_way_o <= '0;
      armed_o    <= 1'b1;
      filling_o  <= 1'b0;
    end else begin
      state_o    <= nxt_state;
      biucmd_o   <= nxt_biucmd;
      fill_way_o <= nxt_fill_way;
      // status follows the state being entered
      armed_o    <= (nxt_state == ARMED);
      filling_o  <= (nxt_state == READ) || (nxt_state == EVICT);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stall towards the core
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    case (state_o)
      ARMED:       stall_o = miss_req_i;
      READ, EVICT: stall_o = ~((biu_ack_i & biu_match_i) | (valid_req_i & cache_hit_i));
      default:     stall_o = 1'b1;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/dcache_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared widths, vector types and encodings for the data cache hit
// stage. Each RTL module pulls these in with a wildcard import in its
// module header.
//////////////////////////////////////////////////////////////////////

`default_nettype none

package dcache_pkg;

  // core word and physical address
  localparam int unsigned XLEN          = 32;
  localparam int unsigned PLEN          = 32;

  // cache line geometry
  localparam int unsigned BLK_BITS      = 128;
  localparam int unsigned BLK_OFFS_BITS = 4;
  localparam int unsigned DAT_OFFS_BITS = 2;
  localparam int unsigned IDX_BITS      = 5;
  localparam int unsigned TAG_BITS      = 23;

  typedef logic [XLEN-1:0]          word_t;
  typedef logic [XLEN/8-1:0]        word_be_t;
  typedef logic [BLK_BITS-1:0]      line_t;
  typedef logic [BLK_BITS/8-1:0]    line_be_t;
  typedef logic [PLEN-1:0]          adr_t;
  typedef logic [IDX_BITS-1:0]      idx_t;
  typedef logic [TAG_BITS-1:0]      tag_t;
  typedef logic [DAT_OFFS_BITS-1:0] dat_offs_t;

  // commands towards the bus interface
  typedef enum logic [1:0] {
    BIUCMD_NOP      = 2'd0,
    BIUCMD_READWAY  = 2'd1,
    BIUCMD_WRITEWAY = 2'd2
  } biucmd_e;

  // miss handling states
  typedef enum logic [2:0] {
    ARMED    = 3'd0,
    READ     = 3'd1,
    EVICT    = 3'd2,
    RECOVER0 = 3'd3,
    RECOVER1 = 3'd4
  } memfsm_state_e;

endpackage

`default_nettype wire

//--- logic/dcache_read_path.sv
//////////////////////////////////////////////////////////////////////
// Load data path. Overlays pending write-buffer bytes on the cache
// line, selects the addressed word and registers data, ack and error
// towards the core.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dcache_read_path import dcache_pkg::*; (
  input  wire logic          clk_i,
  input  wire logic          rst_ni,
  input  wire memfsm_state_e state_i,
  input  wire logic          load_hit_i,
  input  wire idx_t          idx_i,
  input  wire dat_offs_t     dat_offs_i,
  input  wire adr_t          adr_i,
  input  wire line_t         cache_line_i,
  input  wire logic          wb_we_i,
  input  wire idx_t          wb_idx_i,
  input  wire line_be_t      wb_be_i,
  input  wire word_t         wb_data_i,
  input  wire word_t         biu_q_i,
  input  wire logic          biu_ack_i,
  input  wire adr_t          biu_adro_i,
  input  wire logic          biu_err_i,
  input  wire logic          access_err_i,
  output logic               biu_match_o,
  output word_t              q_o,
  output logic               ack_o,
  output logic               err_o
);

  localparam int unsigned WORD_LSB = $clog2(XLEN/8);

  logic  bypass;
  line_t wb_line;
  line_t merged_line;
  word_t cache_q;

  // bus returns the word the core asked for
  assign biu_match_o = (biu_adro_i[PLEN-1:WORD_LSB] == adr_i[PLEN-1:WORD_LSB]);

  assign bypass  = wb_we_i & (idx_i == wb_idx_i);
  assign wb_line = {(BLK_BITS/XLEN){wb_data_i}};

  // byte-wise overlay of the held store
  always_comb begin
    for (int i = 0; i < BLK_BITS/8; i++) begin
      merged_line[i*8 +: 8] = (bypass && wb_be_i[i]) ? wb_line[i*8 +: 8]
                                                     : cache_line_i[i*8 +: 8];
    end
  end

  assign cache_q = merged_line[dat_offs_i*XLEN +: XLEN];

  //////////////////////////////////////////////////////////////////////
  // registered outputs
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ack_o <= 1'b0;
      err_o <= 1'b0;
    end else begin
      case (state_i)
        ARMED:       ack_o <= load_hit_i;
        READ, EVICT: ack_o <= load_hit_i | (biu_ack_i & biu_match_o);
        default:     ack_o <= 1'b0;
      endcase
      err_o <= biu_err_i | access_err_i;
    end
  end

  // during a fill a hit still takes the cache word
  always_ff @(posedge clk_i) begin
    case (state_i)
      READ, EVICT: q_o <= load_hit_i ? cache_q : biu_q_i;
      default:     q_o <= cache_q;
    endcase
  end

endmodule

`default_nettype wire

//--- logic/dcache_req_decode.sv
//////////////////////////////////////////////////////////////////////
// Request decoder. Qualifies the core request against the PMA and PMP
// checks, classifies it and slices the address. Purely combinational.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dcache_req_decode import dcache_pkg::*; (
  input  wire logic req_i,
  input  wire logic wreq_i,
  input  wire logic cacheable_i,
  input  wire logic cache_hit_i,
  input  wire logic pma_exception_i,
  input  wire logic pmp_exception_i,
  input  wire adr_t adr_i,
  output logic      valid_req_o,
  output logic      access_err_o,
  output logic      load_hit_o,
  output logic      store_hit_o,
  output logic      miss_req_o,
  output idx_t      idx_o,
  output tag_t      tag_o,
  output dat_offs_t dat_offs_o
);

  logic exception;
  logic cacheable_hit;

  assign exception     = pma_exception_i | pmp_exception_i;
  assign valid_req_o   = req_i & ~exception;
  assign access_err_o  = req_i & exception;

  assign cacheable_hit = valid_req_o & cacheable_i & cache_hit_i;
  assign load_hit_o    = cacheable_hit & ~wreq_i;
  assign store_hit_o   = cacheable_hit & wreq_i;
  assign miss_req_o    = valid_req_o & cacheable_i & ~cache_hit_i;

  // tag | index | word offset | byte offset
  assign idx_o         = adr_i[BLK_OFFS_BITS +: IDX_BITS];
  assign tag_o         = adr_i[PLEN-1 -: TAG_BITS];
  assign dat_offs_o    = adr_i[BLK_OFFS_BITS-1 -: DAT_OFFS_BITS];

endmodule

`default_nettype wire

//--- logic/dcache_write_buffer.sv
//////////////////////////////////////////////////////////////////////
// Single-entry write buffer. Captures a store hit and presents it to
// the cache memories until they acknowledge the write.
//////////////////////////////////////////////////////////////////////

`default_nettype none

module dcache_write_buffer import dcache_pkg::*; #(
  parameter int unsigned WAYS = 2
) (
  input  wire logic            clk_i,
  input  wire logic            rst_ni,
  input  wire logic            store_hit_i,
  input  wire idx_t            idx_i,
  input  wire dat_offs_t       dat_offs_i,
  input  wire word_t           d_i,
  input  wire word_be_t        be_i,
  input  wire logic [WAYS-1:0] ways_hit_i,
  input  wire logic            writebuffer_ack_i,
  output      logic            we_o,
  output      idx_t            idx_o,
  output      dat_offs_t       offs_o,
  output      word_t           data_o,
  output      line_be_t        be_o,
  output      logic [WAYS-1:0] ways_hit_o
);

  // a new store wins over an ack in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      we_o <= 1'b0;
    end else if (store_hit_i) begin
      we_o <= 1'b1;
    end else if (writebuffer_ack_i) begin
      we_o <= 1'b0;
    end
  end

  // byte enables move to their lane within the line
  always_ff @(posedge clk_i) begin
    if (store_hit_i) begin
      idx_o      <= idx_i;
      offs_o     <= dat_offs_i;
      data_o     <= d_i;
      be_o       <= line_be_t'(be_i) << (dat_offs_i * (XLEN/8));
      ways_hit_o <= ways_hit_i;
    end
  end

endmodule

`default_nettype wire
